/* project.f */
+incdir+tests
src/osc_pkg.sv
src/osc_cfg_if.sv
src/oscillator_apb3_slave.sv
src/phase_accumulator.sv
src/waveform_shaper.sv
src/oscillator_top.sv
tests/tb_oscillator.sv

/* Bender.yml */
package:
  name: oscillator

sources:
  # RTL in compile order
  - src/osc_pkg.sv
  - src/osc_cfg_if.sv
  - src/oscillator_apb3_slave.sv
  - src/phase_accumulator.sv
  - src/waveform_shaper.sv
  - src/oscillator_top.sv

  # Testbench with its stimulus table header
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_oscillator.sv

/* tests/tb_oscillator_table.svh */
`ifndef TB_OSCILLATOR_TABLE_SVH
`define TB_OSCILLATOR_TABLE_SVH

  // One test configuration with the number of samples to check
  typedef struct packed {
    logic [osc_pkg::WAVE_SEL_WIDTH-1:0] wave;
    logic [DATA_W-1:0]                  freq;
    logic [SAMPLE_W-1:0]                duty;
    logic [15:0]                        count;
  } test_entry_t;

  localparam int NUM_TESTS = 10;

  // Columns are waveform code, frequency word, duty cycle and sample count
  // Entry 1 and entry 9 wrap the phase several times
  // Entry 8 repeats entry 0 to show the restart from phase zero
  function automatic test_entry_t table_entry(input int idx);
    case (idx)
      0: table_entry = {osc_pkg::WAVE_SAWTOOTH, 32'h0100_0000, 16'h0000, 16'd40};
      1: table_entry = {osc_pkg::WAVE_SAWTOOTH, 32'h1234_5679, 16'h0000, 16'd40};
      2: table_entry = {osc_pkg::WAVE_TRIANGLE, 32'h0800_0000, 16'h0000, 16'd48};
      3: table_entry = {osc_pkg::WAVE_TRIANGLE, 32'h0345_6789, 16'h0000, 16'd40};
      4: table_entry = {osc_pkg::WAVE_SQUARE,   32'h1000_0000, 16'h0000, 16'd32};
      5: table_entry = {osc_pkg::WAVE_SQUARE,   32'h1000_0000, 16'h8000, 16'd32};
      6: table_entry = {osc_pkg::WAVE_SQUARE,   32'h1111_1111, 16'hFFF0, 16'd32};
      7: table_entry = {2'd3,                   32'h1000_0000, 16'h8000, 16'd16};
      8: table_entry = {osc_pkg::WAVE_SAWTOOTH, 32'h0100_0000, 16'h0000, 16'd24};
      9: table_entry = {osc_pkg::WAVE_TRIANGLE, 32'hFFFF_0000, 16'h0000, 16'd32};
      default: table_entry = '0;
    endcase
  endfunction

  // Reference sample for the n-th accepted sample after enable
  // The phase is n times frequency, wrapped at the data width
  function automatic logic [SAMPLE_W-1:0] expected_sample(
    input logic [osc_pkg::WAVE_SEL_WIDTH-1:0] wave,
    input logic [DATA_W-1:0]                  freq,
    input logic [SAMPLE_W-1:0]                duty,
    input int                                 n
  );
    logic [DATA_W-1:0]   ph;
    logic [SAMPLE_W-1:0] p;
    logic [SAMPLE_W-1:0] folded;
    ph = freq * DATA_W'(n);
    p = ph[DATA_W-1 -: SAMPLE_W];
    // Second half of the period counts back down
    folded = p[SAMPLE_W-1] ? ~p : p;
    if (wave == osc_pkg::WAVE_SQUARE) begin
      expected_sample = (p < duty) ? '1 : '0;
    end else if (wave == osc_pkg::WAVE_SAWTOOTH) begin
      expected_sample = p;
    end else if (wave == osc_pkg::WAVE_TRIANGLE) begin
      expected_sample = folded << 1;
    end else begin
      expected_sample = '0;
    end
  endfunction

`endif

/* tests/tb_oscillator.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_oscillator;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int BASE_ADDR    = 'h400;
  localparam int ADDR_W       = 12;
  localparam int DATA_W       = 32;
  localparam int SAMPLE_W     = 16;

  `include "tb_oscillator_table.svh"

  // Register addresses as seen from the bus
  localparam logic [ADDR_W-1:0] WAVE_ADDR =
    ADDR_W'(BASE_ADDR + osc_pkg::CR_WAVEFORM_SELECT_OFFSET);
  localparam logic [ADDR_W-1:0] FREQ_ADDR = ADDR_W'(BASE_ADDR + osc_pkg::CR_FREQUENCY_OFFSET);
  localparam logic [ADDR_W-1:0] DUTY_ADDR = ADDR_W'(BASE_ADDR + osc_pkg::CR_DUTY_CYCLE_OFFSET);
  localparam logic [ADDR_W-1:0] CTRL_ADDR = ADDR_W'(BASE_ADDR + osc_pkg::CR_CONTROL_OFFSET);

  // Field masks for the read-back of truncated writes
  localparam logic [DATA_W-1:0] WAVE_MASK = DATA_W'(2 ** osc_pkg::WAVE_SEL_WIDTH - 1);
  localparam logic [DATA_W-1:0] DUTY_MASK = DATA_W'(2 ** SAMPLE_W - 1);
  localparam logic [DATA_W-1:0] CTRL_MASK = DATA_W'(1) << osc_pkg::CTRL_ENABLE_BIT;

  // Register test uses 17 transfers, each table entry uses 5
  localparam int APB_TRANSFERS = 17 + NUM_TESTS * 5;

  logic                clk;
  logic                rst_n;
  logic                apb3_psel;
  logic                apb3_penable;
  logic                apb3_pwrite;
  logic [ADDR_W-1:0]   apb3_paddr;
  logic [DATA_W-1:0]   apb3_pwdata;
  logic [DATA_W-1:0]   apb3_prdata;
  logic                apb3_pready;
  logic [SAMPLE_W-1:0] sample;
  logic                sample_valid;
  logic                sample_ready;

  int     error_count;
  int     pass_count;
  int     fail_count;
  integer seed;

  oscillator_top #(
    .APB3_BASE_ADDR_P  (BASE_ADDR),
    .APB3_ADDR_WIDTH_P (ADDR_W),
    .APB3_DATA_WIDTH_P (DATA_W),
    .SAMPLE_WIDTH_P    (SAMPLE_W)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .apb3_psel    (apb3_psel),
    .apb3_penable (apb3_penable),
    .apb3_pwrite  (apb3_pwrite),
    .apb3_paddr   (apb3_paddr),
    .apb3_pwdata  (apb3_pwdata),
    .apb3_prdata  (apb3_prdata),
    .apb3_pready  (apb3_pready),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------
  // Reporting helpers
  // --------------------

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp,
                                 input logic [DATA_W-1:0] act);
    error_count++;
    $display("[ERROR] t=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp, act);
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("Failure at t=%0t: %s", $time, msg);
  endtask

  // A test passes when it added no errors to the running count
  task automatic close_test(input string name, input int start_errors);
    if (error_count == start_errors) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s (%0d errors)", name, error_count - start_errors);
    end
  endtask

  // --------------------
  // APB3 master
  // --------------------

  // Setup cycle, then access cycles until pready, then back to idle
  // pready must appear in the first access cycle and drop right after it
  task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int waited;
    if (apb3_pready !== 1'b0) begin
      report_failure($sformatf("pready high before setup of transfer to 0x%0h", addr));
    end
    apb3_psel    = 1'b1;
    apb3_penable = 1'b0;
    apb3_pwrite  = write;
    apb3_paddr   = addr;
    apb3_pwdata  = wdata;
    @(negedge clk);
    apb3_penable = 1'b1;
    waited = 0;
    while (apb3_pready !== 1'b1 && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (apb3_pready !== 1'b1) begin
      report_failure($sformatf("no pready for transfer to 0x%0h", addr));
    end else if (waited != 0) begin
      report_failure($sformatf("pready late by %0d cycles at 0x%0h", waited, addr));
    end
    rdata = apb3_prdata;
    @(negedge clk);
    apb3_psel    = 1'b0;
    apb3_penable = 1'b0;
    apb3_pwrite  = 1'b0;
    if (apb3_pready !== 1'b0) begin
      report_failure($sformatf("pready stayed high after transfer to 0x%0h", addr));
    end
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] unused;
    apb_transfer(1'b1, addr, wdata, unused);
  endtask

  task automatic apb_read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                                input string name);
    logic [DATA_W-1:0] rdata;
    apb_transfer(1'b0, addr, '0, rdata);
    if (rdata !== exp) begin
      report_mismatch($sformatf("apb3_prdata (%s)", name), exp, rdata);
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic run_register_test();
    int start_errors;
    start_errors = error_count;
    if (sample_valid !== 1'b0) begin
      report_mismatch("sample_valid", 0, sample_valid);
    end
    // Everything reads zero straight out of reset
    apb_read_check(WAVE_ADDR, '0, "waveform_select");
    apb_read_check(FREQ_ADDR, '0, "frequency");
    apb_read_check(DUTY_ADDR, '0, "duty_cycle");
    apb_read_check(CTRL_ADDR, '0, "control");
    apb_write(WAVE_ADDR, 32'hFFFF_FFFF);
    apb_write(FREQ_ADDR, 32'hDEAD_BEEF);
    apb_write(DUTY_ADDR, 32'h1234_ABCD);
    apb_read_check(WAVE_ADDR, 32'hFFFF_FFFF & WAVE_MASK, "waveform_select");
    apb_read_check(FREQ_ADDR, 32'hDEAD_BEEF, "frequency");
    apb_read_check(DUTY_ADDR, 32'h1234_ABCD & DUTY_MASK, "duty_cycle");
    apb_write(CTRL_ADDR, 32'hFFFF_FFFF);
    apb_read_check(CTRL_ADDR, 32'hFFFF_FFFF & CTRL_MASK, "control");
    apb_write(CTRL_ADDR, '0);
    apb_read_check(CTRL_ADDR, '0, "control");
    // Gaps in the map and addresses outside it
    apb_read_check(ADDR_W'(BASE_ADDR + 16), '0, "unmapped");
    apb_read_check(ADDR_W'(BASE_ADDR + 2), '0, "unmapped");
    apb_read_check(ADDR_W'(0), '0, "unmapped");
    close_test("register access", start_errors);
  endtask

  // Accepts samples under random sample_ready and checks each one
  // A stalled sample has to stay put until it is taken
  task automatic collect_samples(input test_entry_t e);
    int                  n;
    logic                held_pending;
    logic [SAMPLE_W-1:0] held;
    logic [SAMPLE_W-1:0] exp;
    logic [31:0]         rnd;
    n = 0;
    held_pending = 1'b0;
    held = '0;
    while (n < int'(e.count)) begin
      @(negedge clk);
      if (held_pending) begin
        if (sample_valid !== 1'b1) begin
          report_mismatch("sample_valid (stalled)", 1, sample_valid);
        end else if (sample !== held) begin
          report_mismatch("sample (stalled)", held, sample);
        end
      end
      rnd = $random(seed);
      sample_ready = rnd[0];
      held_pending = 1'b0;
      if (sample_valid === 1'b1) begin
        if (sample_ready) begin
          exp = expected_sample(e.wave, e.freq, e.duty, n);
          if (sample !== exp) begin
            report_mismatch($sformatf("sample[%0d]", n), exp, sample);
          end
          n++;
        end else begin
          held_pending = 1'b1;
          held = sample;
        end
      end
    end
    @(negedge clk);
    sample_ready = 1'b0;
  endtask

  task automatic run_table_entry(input int idx);
    test_entry_t e;
    int          start_errors;
    e = table_entry(idx);
    start_errors = error_count;
    // Disabled oscillator must not offer samples
    apb_write(CTRL_ADDR, '0);
    repeat (2) begin
      @(negedge clk);
      if (sample_valid !== 1'b0) begin
        report_mismatch("sample_valid", 0, sample_valid);
      end
    end
    apb_write(WAVE_ADDR, DATA_W'(e.wave));
    apb_write(FREQ_ADDR, e.freq);
    apb_write(DUTY_ADDR, DATA_W'(e.duty));
    apb_write(CTRL_ADDR, CTRL_MASK);
    collect_samples(e);
    close_test($sformatf("test %0d wave=%0d freq=0x%08h duty=0x%04h samples=%0d",
                         idx, e.wave, e.freq, e.duty, e.count), start_errors);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    seed         = 32608;
    error_count  = 0;
    pass_count   = 0;
    fail_count   = 0;
    rst_n        = 1'b0;
    apb3_psel    = 1'b0;
    apb3_penable = 1'b0;
    apb3_pwrite  = 1'b0;
    apb3_paddr   = '0;
    apb3_pwdata  = '0;
    sample_ready = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    run_register_test();
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_table_entry(i);
    end
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Budget of ten cycles per sample plus the register traffic
  initial begin : watchdog
    test_entry_t e;
    int          total;
    int          limit;
    total = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      e = table_entry(i);
      total += int'(e.count);
    end
    limit = total * 10 + APB_TRANSFERS * 3 + NUM_TESTS * 3 + RESET_CYCLES + 32;
    #(limit * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the samples stopped arriving", limit);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src/oscillator_top.sv */
`timescale 1ns/1ps
`default_nettype none

module oscillator_top #(
  parameter int APB3_BASE_ADDR_P  = 0,
  parameter int APB3_ADDR_WIDTH_P = 12,
  parameter int APB3_DATA_WIDTH_P = 32,
  parameter int SAMPLE_WIDTH_P    = 16
) (
  input  wire                          clk,
  input  wire                          rst_n,

  // APB3 register port
  input  wire                          apb3_psel,
  input  wire                          apb3_penable,
  input  wire                          apb3_pwrite,
  input  wire  [APB3_ADDR_WIDTH_P-1:0] apb3_paddr,
  input  wire  [APB3_DATA_WIDTH_P-1:0] apb3_pwdata,
  output wire  [APB3_DATA_WIDTH_P-1:0] apb3_prdata,
  output wire                          apb3_pready,

  // Sample output stream
  output wire  [SAMPLE_WIDTH_P-1:0]    sample,
  output wire                          sample_valid,
  input  wire                          sample_ready
);

  // Phase stream between accumulator and shaper
  wire [APB3_DATA_WIDTH_P-1:0] phase;
  wire                         phase_valid;
  wire                         phase_ready;

  // Configuration shared by the register slave and the datapath
  osc_cfg_if #(
    .DATA_WIDTH   (APB3_DATA_WIDTH_P),
    .SAMPLE_WIDTH (SAMPLE_WIDTH_P)
  ) cfg_bus ();

  oscillator_apb3_slave #(
    .APB3_BASE_ADDR_P  (APB3_BASE_ADDR_P),
    .APB3_ADDR_WIDTH_P (APB3_ADDR_WIDTH_P),
    .APB3_DATA_WIDTH_P (APB3_DATA_WIDTH_P)
  ) apb_slave_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .apb3_psel    (apb3_psel),
    .apb3_penable (apb3_penable),
    .apb3_pwrite  (apb3_pwrite),
    .apb3_paddr   (apb3_paddr),
    .apb3_pwdata  (apb3_pwdata),
    .apb3_pready  (apb3_pready),
    .apb3_prdata  (apb3_prdata),
    .cfg          (cfg_bus.regs)
  );

  phase_accumulator #(
    .APB3_DATA_WIDTH_P (APB3_DATA_WIDTH_P)
  ) phase_acc_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg_bus.core),
    .phase       (phase),
    .phase_valid (phase_valid),
    .phase_ready (phase_ready)
  );

  waveform_shaper #(
    .APB3_DATA_WIDTH_P (APB3_DATA_WIDTH_P),
    .SAMPLE_WIDTH_P    (SAMPLE_WIDTH_P)
  ) shaper_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg_bus.core),
    .phase        (phase),
    .phase_valid  (phase_valid),
    .phase_ready  (phase_ready),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready)
  );

endmodule

`default_nettype wire

/* src/waveform_shaper.sv */
`timescale 1ns/1ps
`default_nettype none

module waveform_shaper #(
  parameter int APB3_DATA_WIDTH_P = 32,
  parameter int SAMPLE_WIDTH_P    = 16
) (
  input  wire                          clk,
  input  wire                          rst_n,

  osc_cfg_if.core                      cfg,

  input  wire  [APB3_DATA_WIDTH_P-1:0] phase,
  input  wire                          phase_valid,
  output logic                         phase_ready,

  output logic [SAMPLE_WIDTH_P-1:0]    sample,
  output logic                         sample_valid,
  input  wire                          sample_ready
);

  logic [SAMPLE_WIDTH_P-1:0] phase_top;
  logic [SAMPLE_WIDTH_P-1:0] shaped;
  logic                      phase_fire;

  // Only the upper phase bits set the sample, the rest is fractional phase
  assign phase_top = phase[APB3_DATA_WIDTH_P-1 -: SAMPLE_WIDTH_P];

  // Output register can take a new sample when empty or being drained now
  assign phase_ready = !sample_valid || sample_ready;
  assign phase_fire  = phase_valid && phase_ready;

  // --------------------
  // Waveform generation
  // --------------------

  always_comb begin
    case (cfg.waveform_select)
      // Full scale below the duty threshold, zero above it
      osc_pkg::WAVE_SQUARE: begin
        shaped = (phase_top < cfg.duty_cycle) ? {SAMPLE_WIDTH_P{1'b1}} : '0;
      end
      // Ramp follows the phase directly
      osc_pkg::WAVE_SAWTOOTH: begin
        shaped = phase_top;
      end
      // First half rises, second half mirrors it downward
      osc_pkg::WAVE_TRIANGLE: begin
        if (phase_top[SAMPLE_WIDTH_P-1]) begin
          shaped = {~phase_top[SAMPLE_WIDTH_P-2:0], 1'b0};
        end else begin
          shaped = {phase_top[SAMPLE_WIDTH_P-2:0], 1'b0};
        end
      end
      // Unused code gives silence
      default: begin
        shaped = '0;
      end
    endcase
  end

  // --------------------
  // Output register
  // --------------------

  // Valid only moves when the register is free to accept
  // Disabling the oscillator flushes any pending sample
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_valid <= 1'b0;
    end else if (!cfg.enable) begin
      sample_valid <= 1'b0;
    end else if (phase_ready) begin
      sample_valid <= phase_valid;
    end
  end

  // Sample payload is loaded on every phase transfer and held otherwise
  always_ff @(posedge clk) begin
    if (phase_fire) begin
      sample <= shaped;
    end
  end

  // A stalled sample is presented unchanged until the sink takes it
  sample_hold_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    sample_valid && !sample_ready && cfg.enable |=> sample_valid && $stable(sample)
  );

endmodule

`default_nettype wire

/* src/phase_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_accumulator #(
  parameter int APB3_DATA_WIDTH_P = 32
) (
  input  wire                          clk,
  input  wire                          rst_n,

  osc_cfg_if.core                      cfg,

  output logic [APB3_DATA_WIDTH_P-1:0] phase,
  output logic                         phase_valid,
  input  wire                          phase_ready
);

  logic phase_fire;

  // A phase is handed to the shaper when both sides agree
  assign phase_fire = phase_valid && phase_ready;

  // --------------------
  // Phase register
  // --------------------

  // While disabled the accumulator sits at phase zero with no valid output
  // After enable rises, valid follows one cycle later with phase zero
  // Each transfer steps the phase by the current frequency word
  // The sum wraps naturally at the data width, giving the NCO period
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase       <= '0;
      phase_valid <= 1'b0;
    end else if (!cfg.enable) begin
      phase       <= '0;
      phase_valid <= 1'b0;
    end else begin
      // Valid stays asserted for as long as the oscillator runs
      phase_valid <= 1'b1;
      if (phase_fire) begin
        phase <= phase + cfg.frequency;
      end
    end
  end

  // --------------------
  // Stream checks
  // --------------------

  // A stalled phase must be offered again unchanged on the next cycle
  // This ties the shaper back-pressure to the accumulator hold behaviour
  phase_hold_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    phase_valid && !phase_ready && cfg.enable |=> phase_valid && $stable(phase)
  );

endmodule

`default_nettype wire

/* src/oscillator_apb3_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module oscillator_apb3_slave #(
  parameter int APB3_BASE_ADDR_P  = 0,
  parameter int APB3_ADDR_WIDTH_P = 12,
  parameter int APB3_DATA_WIDTH_P = 32
) (
  input  wire                           clk,
  input  wire                           rst_n,

  input  wire                           apb3_psel,
  input  wire                           apb3_penable,
  input  wire                           apb3_pwrite,
  input  wire  [APB3_ADDR_WIDTH_P-1:0]  apb3_paddr,
  input  wire  [APB3_DATA_WIDTH_P-1:0]  apb3_pwdata,
  output logic                          apb3_pready,
  output logic [APB3_DATA_WIDTH_P-1:0]  apb3_prdata,

  osc_cfg_if.regs                       cfg
);

  // Duty cycle width follows the sample width carried by the interface
  localparam int DUTY_WIDTH_C = $bits(cfg.duty_cycle);

  // Absolute register addresses
  localparam logic [APB3_ADDR_WIDTH_P-1:0] WAVE_ADDR_C =
    APB3_ADDR_WIDTH_P'(APB3_BASE_ADDR_P + osc_pkg::CR_WAVEFORM_SELECT_OFFSET);
  localparam logic [APB3_ADDR_WIDTH_P-1:0] FREQ_ADDR_C =
    APB3_ADDR_WIDTH_P'(APB3_BASE_ADDR_P + osc_pkg::CR_FREQUENCY_OFFSET);
  localparam logic [APB3_ADDR_WIDTH_P-1:0] DUTY_ADDR_C =
    APB3_ADDR_WIDTH_P'(APB3_BASE_ADDR_P + osc_pkg::CR_DUTY_CYCLE_OFFSET);
  localparam logic [APB3_ADDR_WIDTH_P-1:0] CTRL_ADDR_C =
    APB3_ADDR_WIDTH_P'(APB3_BASE_ADDR_P + osc_pkg::CR_CONTROL_OFFSET);

  logic                         setup_phase;
  logic                         write_en;
  logic [APB3_DATA_WIDTH_P-1:0] read_data;

  // First cycle of a transfer, psel high with penable still low
  assign setup_phase = apb3_psel && !apb3_penable;

  // The write commits in the access cycle where pready is already high
  assign write_en = apb3_psel && apb3_penable && apb3_pready && apb3_pwrite;

  // --------------------
  // Read mux
  // --------------------

  // Register values are zero-extended to the bus width
  // Unmapped addresses fall through to zero
  always_comb begin
    read_data = '0;
    case (apb3_paddr)
      WAVE_ADDR_C: read_data[osc_pkg::WAVE_SEL_WIDTH-1:0] = cfg.waveform_select;
      FREQ_ADDR_C: read_data = cfg.frequency;
      DUTY_ADDR_C: read_data[DUTY_WIDTH_C-1:0] = cfg.duty_cycle;
      CTRL_ADDR_C: read_data[osc_pkg::CTRL_ENABLE_BIT] = cfg.enable;
      default:     read_data = '0;
    endcase
  end

  // --------------------
  // Transfer handshake
  // --------------------

  // pready rises at the edge closing the setup cycle and drops after one cycle
  // Read data is captured at that same edge, so it lines up with pready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      apb3_pready <= 1'b0;
      apb3_prdata <= '0;
    end else begin
      apb3_pready <= setup_phase;
      apb3_prdata <= (setup_phase && !apb3_pwrite) ? read_data : '0;
    end
  end

  // --------------------
  // Configuration registers
  // --------------------

  // Write data is truncated to each field width
  // All registers clear on reset, which leaves the oscillator disabled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.waveform_select <= '0;
      cfg.frequency       <= '0;
      cfg.duty_cycle      <= '0;
      cfg.enable          <= 1'b0;
    end else if (write_en) begin
      case (apb3_paddr)
        WAVE_ADDR_C: cfg.waveform_select <= apb3_pwdata[osc_pkg::WAVE_SEL_WIDTH-1:0];
        FREQ_ADDR_C: cfg.frequency       <= apb3_pwdata;
        DUTY_ADDR_C: cfg.duty_cycle      <= apb3_pwdata[DUTY_WIDTH_C-1:0];
        CTRL_ADDR_C: cfg.enable          <= apb3_pwdata[osc_pkg::CTRL_ENABLE_BIT];
        default: ;
      endcase
    end
  end

  // --------------------
  // Protocol checks
  // --------------------

  // The master never drives an access phase without selecting the slave
  penable_needs_psel_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    apb3_penable |-> apb3_psel
  );

  // Address is held from the setup cycle through the access phase
  paddr_stable_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    apb3_psel && apb3_penable |-> $stable(apb3_paddr)
  );

endmodule

`default_nettype wire

/* src/osc_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface osc_cfg_if #(
  parameter int DATA_WIDTH   = 32,
  parameter int SAMPLE_WIDTH = 16
) ();

  // Selected waveform code
  logic [osc_pkg::WAVE_SEL_WIDTH-1:0] waveform_select;

  // Phase step added on every accepted phase
  logic [DATA_WIDTH-1:0]              frequency;

  // Square wave threshold in sample units
  logic [SAMPLE_WIDTH-1:0]            duty_cycle;

  // Oscillator run enable
  logic                               enable;

  // Register side owns all configuration state
  modport regs (output waveform_select, frequency, duty_cycle, enable);

  // Datapath side only observes the configuration
  modport core (input waveform_select, frequency, duty_cycle, enable);

endinterface

`default_nettype wire

/* src/osc_pkg.sv */
`default_nettype none

package osc_pkg;

  // --------------------
  // Register map
  // --------------------

  // Byte offsets of the configuration registers from the slave base address
  // Each register occupies one 32-bit word slot on the APB3 bus
  localparam int CR_WAVEFORM_SELECT_OFFSET = 0;

  // Phase increment per accepted sample, the full data width is used
  localparam int CR_FREQUENCY_OFFSET = 4;

  // Square wave threshold, compared against the upper phase bits
  localparam int CR_DUTY_CYCLE_OFFSET = 8;

  // Control word, only the enable bit is implemented
  localparam int CR_CONTROL_OFFSET = 12;

  // Bit position of the oscillator enable inside the control register
  localparam int CTRL_ENABLE_BIT = 0;

  // --------------------
  // Waveform selection
  // --------------------

  // Width of the waveform select field
  localparam int WAVE_SEL_WIDTH = 2;

  // Square wave, high while the phase is below the duty cycle
  localparam logic [WAVE_SEL_WIDTH-1:0] WAVE_SQUARE = WAVE_SEL_WIDTH'(0);

  // Rising ramp that follows the phase directly
  localparam logic [WAVE_SEL_WIDTH-1:0] WAVE_SAWTOOTH = WAVE_SEL_WIDTH'(1);

  // Symmetric ramp up then down over one phase period
  localparam logic [WAVE_SEL_WIDTH-1:0] WAVE_TRIANGLE = WAVE_SEL_WIDTH'(2);

  // The remaining code 3 is not named here
  // The shaper outputs constant zero samples for it

endpackage

`default_nettype wire
